/* all.f */
src/npc_mem_pkg.sv
src/pmem_sram.sv
src/serial_sink.sv
src/mem_region_map.sv
src/axi_mem_slave.sv
src/npc_mem_top.sv
bench/npc_mem_chk.sv
bench/tb_npc_mem.sv

/* bench/npc_mem_chk.sv */
`timescale 1ns/1ps

module npc_mem_chk #(
	parameter int PMEM_WORDS = 1024
) (
	input logic                  clk,
	input logic                  rst,
	input logic                  ar_valid,
	input logic                  ar_ready,
	input logic                  aw_valid,
	input logic                  aw_ready,
	input logic                  r_valid,
	input npc_mem_pkg::axi_r_t   r,
	input logic                  r_ready,
	input logic                  b_valid,
	input npc_mem_pkg::axi_b_t   b,
	input logic                  b_ready,
	input logic                  req_valid,
	input npc_mem_pkg::mem_req_t req,
	input logic                  req_ready,
	input npc_mem_pkg::resp_t    wr_resp,
	input npc_mem_pkg::resp_t    rsp_resp
);

	int fail_count = 0;

	// open from an address handshake until the last R beat or the B handshake
	logic busy;

	// true when no target answers at this word address
	function automatic logic unmapped(input npc_mem_pkg::addr_t a);
		logic in_pmem;
		logic in_boot;
		in_pmem = (a >= npc_mem_pkg::PMEM_BASE) &&
			(a < npc_mem_pkg::PMEM_BASE + npc_mem_pkg::addr_t'(PMEM_WORDS * 4));
		in_boot = (a >= npc_mem_pkg::BOOT_BASE) && (a < npc_mem_pkg::BOOT_BASE + 32'd16);
		return !in_pmem && !in_boot && (a != npc_mem_pkg::SERIAL_ADDR);
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
		end else if ((ar_valid && ar_ready) || (aw_valid && aw_ready)) begin
			busy <= 1'b1;
		end else if ((r_valid && r_ready && r.last) || (b_valid && b_ready)) begin
			busy <= 1'b0;
		end
	end

	a_r_stable: assert property (@(posedge clk) disable iff (rst)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else begin
			fail_count++;
			$error("r_valid or R payload changed before r_ready");
		end

	a_b_stable: assert property (@(posedge clk) disable iff (rst)
		b_valid && !b_ready |=> b_valid && $stable(b))
		else begin
			fail_count++;
			$error("b_valid or B payload changed before b_ready");
		end

	a_addr_ready_busy: assert property (@(posedge clk) disable iff (rst)
		busy |-> !ar_ready && !aw_ready)
		else begin
			fail_count++;
			$error("address channel ready while a burst is open");
		end

	// unmapped beats must never come back OKAY
	a_unmapped_wr: assert property (@(posedge clk) disable iff (rst)
		req_valid && req_ready && req.we && unmapped(req.addr)
		|-> wr_resp != npc_mem_pkg::RESP_OKAY)
		else begin
			fail_count++;
			$error("unmapped write answered OKAY");
		end

	a_unmapped_rd: assert property (@(posedge clk) disable iff (rst)
		req_valid && req_ready && !req.we && unmapped(req.addr)
		|=> rsp_resp != npc_mem_pkg::RESP_OKAY)
		else begin
			fail_count++;
			$error("unmapped read answered OKAY");
		end

endmodule

bind axi_mem_slave npc_mem_chk u_npc_mem_chk (
	.clk       (clk),
	.rst       (rst),
	.ar_valid  (ar_valid),
	.ar_ready  (ar_ready),
	.aw_valid  (aw_valid),
	.aw_ready  (aw_ready),
	.r_valid   (r_valid),
	.r         (r),
	.r_ready   (r_ready),
	.b_valid   (b_valid),
	.b         (b),
	.b_ready   (b_ready),
	.req_valid (req_valid),
	.req       (req),
	.req_ready (req_ready),
	.wr_resp   (wr_resp),
	.rsp_resp  (rsp_resp)
);

/* bench/tb_npc_mem.sv */
`timescale 1ns/1ps

module tb_npc_mem;

	localparam int PMEM_WORDS = 1024;
	localparam int SERIAL_DEPTH = 4;
	// about 100 beats plus serial stall and handshakes, well under 500 cycles
	localparam int TIMEOUT_CYCLES = 4000;

	logic clk;
	logic rst;
	logic aw_valid;
	npc_mem_pkg::axi_aw_t aw;
	logic aw_ready;
	logic w_valid;
	npc_mem_pkg::axi_w_t w;
	logic w_ready;
	logic b_valid;
	npc_mem_pkg::axi_b_t b;
	logic b_ready;
	logic ar_valid;
	npc_mem_pkg::axi_ar_t ar;
	logic ar_ready;
	logic r_valid;
	npc_mem_pkg::axi_r_t r;
	logic r_ready;
	logic serial_valid;
	logic [7:0] serial_byte;
	logic serial_ready;

	// reference image of program memory
	npc_mem_pkg::data_t ref_mem [PMEM_WORDS];

	// beats to send and beats received
	npc_mem_pkg::data_t wr_data_q[$];
	npc_mem_pkg::strb_t wr_strb_q[$];
	npc_mem_pkg::data_t rd_data_q[$];
	npc_mem_pkg::resp_t rd_resp_q[$];
	npc_mem_pkg::axi_id_t rd_id_q[$];
	logic rd_last_q[$];
	logic [7:0] ser_got_q[$];

	npc_mem_pkg::data_t rng;
	string cur_test;
	int err_count;
	int test_errs_start;
	int tests_run;
	int tests_failed;
	int assert_fails;
	int cycles;
	int b_done_cycle;
	int drain_start_cycle;

	npc_mem_top #(
		.PMEM_WORDS   (PMEM_WORDS),
		.SERIAL_DEPTH (SERIAL_DEPTH)
	) u_npc_mem_top (
		.clk          (clk),
		.rst          (rst),
		.aw_valid     (aw_valid),
		.aw           (aw),
		.aw_ready     (aw_ready),
		.w_valid      (w_valid),
		.w            (w),
		.w_ready      (w_ready),
		.b_valid      (b_valid),
		.b            (b),
		.b_ready      (b_ready),
		.ar_valid     (ar_valid),
		.ar           (ar),
		.ar_ready     (ar_ready),
		.r_valid      (r_valid),
		.r            (r),
		.r_ready      (r_ready),
		.serial_valid (serial_valid),
		.serial_byte  (serial_byte),
		.serial_ready (serial_ready)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("simulation timed out after %0d cycles", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	function automatic npc_mem_pkg::data_t xorshift32(input npc_mem_pkg::data_t x);
		npc_mem_pkg::data_t y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// jump-to-program stub as the boot ROM should hold it
	function automatic npc_mem_pkg::data_t expected_boot_word(input int i);
		case (i)
			0: return 32'h8000_0137;
			1: return 32'h0001_0067;
			default: return 32'h0;
		endcase
	endfunction

	function automatic npc_mem_pkg::data_t model_read(input npc_mem_pkg::addr_t addr);
		npc_mem_pkg::addr_t off;
		off = addr - npc_mem_pkg::PMEM_BASE;
		if (off < PMEM_WORDS * 4) begin
			return ref_mem[off[31:2]];
		end
		return '0;
	endfunction

	// merge strobed bytes, words outside program memory are dropped
	task automatic model_write(input npc_mem_pkg::addr_t addr, input npc_mem_pkg::data_t data,
			input npc_mem_pkg::strb_t strb);
		npc_mem_pkg::addr_t off;
		int i;
		off = addr - npc_mem_pkg::PMEM_BASE;
		if (off < PMEM_WORDS * 4) begin
			for (i = 0; i < 4; i++) begin
				if (strb[i]) begin
					ref_mem[off[31:2]][8*i +: 8] = data[8*i +: 8];
				end
			end
		end
	endtask

	task automatic model_burst(input npc_mem_pkg::addr_t base);
		int i;
		for (i = 0; i < wr_data_q.size(); i++) begin
			model_write(base + npc_mem_pkg::addr_t'(4 * i), wr_data_q[i], wr_strb_q[i]);
		end
	endtask

	task automatic load_beats(input int beats, input bit partial);
		int i;
		wr_data_q.delete();
		wr_strb_q.delete();
		for (i = 0; i < beats; i++) begin
			rng = xorshift32(rng);
			wr_data_q.push_back(rng);
			if (partial) begin
				rng = xorshift32(rng);
				wr_strb_q.push_back(rng[3:0]);
			end else begin
				wr_strb_q.push_back(4'hf);
			end
		end
	endtask

	task automatic check_data(input string what, input npc_mem_pkg::data_t exp,
			input npc_mem_pkg::data_t act);
		if (act !== exp) begin
			$display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic check_resp(input string what, input npc_mem_pkg::resp_t exp,
			input npc_mem_pkg::resp_t act);
		if (act !== exp) begin
			$display("ERR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic check_id(input string what, input npc_mem_pkg::axi_id_t exp,
			input npc_mem_pkg::axi_id_t act);
		if (act !== exp) begin
			$display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic check_count(input string what, input int exp, input int act);
		if (act != exp) begin
			$display("ERR %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errs_start = err_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (err_count == test_errs_start) begin
			$display("%s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", cur_test, err_count - test_errs_start);
		end
	endtask

	// inputs move on falling edges, outputs are sampled 1 ns later
	task automatic axi_write_burst(input npc_mem_pkg::axi_id_t id, input npc_mem_pkg::addr_t addr,
			input npc_mem_pkg::axi_len_t len, input npc_mem_pkg::axi_burst_t burst,
			output npc_mem_pkg::axi_b_t bresp);
		int beat;
		@(negedge clk);
		aw.id = id;
		aw.addr = addr;
		aw.len = len;
		aw.size = 3'd2;
		aw.burst = burst;
		aw_valid = 1'b1;
		#1;
		while (!aw_ready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		aw_valid = 1'b0;
		beat = 0;
		while (beat <= int'(len)) begin
			w.data = wr_data_q[beat];
			w.strb = wr_strb_q[beat];
			w.last = (beat == int'(len));
			w_valid = 1'b1;
			#1;
			if (w_ready) begin
				beat++;
			end
			@(negedge clk);
		end
		w_valid = 1'b0;
		// B is stalled for one cycle so the slave must hold it
		@(negedge clk);
		b_ready = 1'b1;
		#1;
		while (!b_valid) begin
			@(negedge clk);
			#1;
		end
		bresp = b;
		b_done_cycle = cycles;
		@(negedge clk);
		b_ready = 1'b0;
	endtask

	// latency counts edges from the AR handshake to the first r_valid
	task automatic axi_read_burst(input npc_mem_pkg::axi_id_t id, input npc_mem_pkg::addr_t addr,
			input npc_mem_pkg::axi_len_t len, input npc_mem_pkg::axi_burst_t burst,
			input bit throttle, output int latency);
		int got;
		int waited;
		rd_data_q.delete();
		rd_resp_q.delete();
		rd_id_q.delete();
		rd_last_q.delete();
		latency = -1;
		@(negedge clk);
		ar.id = id;
		ar.addr = addr;
		ar.len = len;
		ar.size = 3'd2;
		ar.burst = burst;
		ar_valid = 1'b1;
		#1;
		while (!ar_ready) begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		ar_valid = 1'b0;
		got = 0;
		waited = 0;
		while (got <= int'(len)) begin
			if (throttle) begin
				rng = xorshift32(rng);
				r_ready = rng[0];
			end else begin
				r_ready = 1'b1;
			end
			#1;
			if (r_valid && latency < 0) begin
				latency = waited;
			end
			if (r_valid && r_ready) begin
				rd_data_q.push_back(r.data);
				rd_resp_q.push_back(r.resp);
				rd_id_q.push_back(r.id);
				rd_last_q.push_back(r.last);
				got++;
			end
			@(negedge clk);
			waited++;
		end
		r_ready = 1'b0;
		#1;
		if (r_valid) begin
			$display("%s: read returned a beat beyond the burst length", cur_test);
			err_count++;
		end
	endtask

	// holds serial_ready low for a while, then collects bytes
	task automatic drain_serial(input int hold_cycles, input int count);
		int n;
		serial_ready = 1'b0;
		repeat (hold_cycles) @(negedge clk);
		drain_start_cycle = cycles;
		n = 0;
		while (n < count) begin
			serial_ready = 1'b1;
			#1;
			if (serial_valid) begin
				ser_got_q.push_back(serial_byte);
				n++;
			end
			@(negedge clk);
		end
		serial_ready = 1'b0;
	endtask

	task automatic check_pmem_beats(input npc_mem_pkg::addr_t addr, input int beats,
			input npc_mem_pkg::axi_id_t id);
		int i;
		check_count("read beats", beats, rd_data_q.size());
		for (i = 0; i < rd_data_q.size(); i++) begin
			check_data("read data", model_read(addr + npc_mem_pkg::addr_t'(4 * i)), rd_data_q[i]);
			check_id("read id", id, rd_id_q[i]);
			check_resp("read resp", npc_mem_pkg::RESP_OKAY, rd_resp_q[i]);
			check_flag("read last", i == beats - 1, rd_last_q[i]);
		end
	endtask

	task automatic check_boot_beats(input npc_mem_pkg::axi_id_t id);
		int i;
		check_count("boot beats", 4, rd_data_q.size());
		for (i = 0; i < rd_data_q.size(); i++) begin
			check_data("boot word", expected_boot_word(i), rd_data_q[i]);
			check_id("boot id", id, rd_id_q[i]);
			check_resp("boot resp", npc_mem_pkg::RESP_OKAY, rd_resp_q[i]);
			check_flag("boot last", i == 3, rd_last_q[i]);
		end
	endtask

	task automatic test_boot_stub();
		int lat;
		begin_test("boot_stub");
		axi_read_burst(4'd5, npc_mem_pkg::BOOT_BASE, 8'd3, npc_mem_pkg::BURST_INCR, 1'b0, lat);
		check_boot_beats(4'd5);
		end_test();
	endtask

	task automatic test_strobed_write();
		npc_mem_pkg::axi_b_t bresp;
		npc_mem_pkg::addr_t base;
		int lat;
		begin_test("strobed_write");
		base = npc_mem_pkg::PMEM_BASE + 32'h40;
		// full words first so partial strobes have something to merge into
		load_beats(8, 1'b0);
		axi_write_burst(4'd3, base, 8'd7, npc_mem_pkg::BURST_INCR, bresp);
		model_burst(base);
		load_beats(8, 1'b1);
		axi_write_burst(4'd3, base, 8'd7, npc_mem_pkg::BURST_INCR, bresp);
		check_resp("b resp", npc_mem_pkg::RESP_OKAY, bresp.resp);
		check_id("b id", 4'd3, bresp.id);
		model_burst(base);
		axi_read_burst(4'd9, base, 8'd7, npc_mem_pkg::BURST_INCR, 1'b0, lat);
		check_pmem_beats(base, 8, 4'd9);
		end_test();
	endtask

	task automatic test_read_backpressure();
		npc_mem_pkg::axi_b_t bresp;
		npc_mem_pkg::addr_t base;
		int lat;
		begin_test("read_backpressure");
		base = npc_mem_pkg::PMEM_BASE + 32'h200;
		load_beats(16, 1'b0);
		axi_write_burst(4'd4, base, 8'd15, npc_mem_pkg::BURST_INCR, bresp);
		check_resp("b resp", npc_mem_pkg::RESP_OKAY, bresp.resp);
		model_burst(base);
		axi_read_burst(4'd6, base, 8'd15, npc_mem_pkg::BURST_INCR, 1'b1, lat);
		check_count("first r_valid latency", 2, lat);
		check_pmem_beats(base, 16, 4'd6);
		end_test();
	endtask

	task automatic test_serial_out();
		npc_mem_pkg::axi_b_t bresp;
		int i;
		begin_test("serial_out");
		load_beats(6, 1'b0);
		ser_got_q.delete();
		fork
			axi_write_burst(4'd7, npc_mem_pkg::SERIAL_ADDR, 8'd5, npc_mem_pkg::BURST_FIXED, bresp);
			drain_serial(15, 6);
		join
		check_resp("b resp", npc_mem_pkg::RESP_OKAY, bresp.resp);
		check_id("b id", 4'd7, bresp.id);
		if (b_done_cycle <= drain_start_cycle) begin
			$display("%s: serial burst finished before draining began", cur_test);
			err_count++;
		end
		check_count("serial bytes", 6, ser_got_q.size());
		for (i = 0; i < ser_got_q.size(); i++) begin
			check_byte("serial byte", wr_data_q[i][7:0], ser_got_q[i]);
		end
		end_test();
	endtask

	task automatic test_error_responses();
		npc_mem_pkg::axi_b_t bresp;
		npc_mem_pkg::addr_t base;
		int lat;
		begin_test("error_responses");
		axi_read_burst(4'd1, 32'h1000_0000, 8'd0, npc_mem_pkg::BURST_INCR, 1'b0, lat);
		check_count("unmapped beats", 1, rd_data_q.size());
		if (rd_data_q.size() > 0) begin
			check_resp("unmapped resp", npc_mem_pkg::RESP_DECERR, rd_resp_q[0]);
			check_data("unmapped data", 32'h0, rd_data_q[0]);
			check_flag("unmapped last", 1'b1, rd_last_q[0]);
		end
		// boot ROM is read only
		load_beats(1, 1'b0);
		axi_write_burst(4'd2, npc_mem_pkg::BOOT_BASE, 8'd0, npc_mem_pkg::BURST_INCR, bresp);
		check_resp("boot write resp", npc_mem_pkg::RESP_SLVERR, bresp.resp);
		axi_read_burst(4'd2, npc_mem_pkg::BOOT_BASE, 8'd3, npc_mem_pkg::BURST_INCR, 1'b0, lat);
		check_boot_beats(4'd2);
		// last two beats fall past the end of program memory
		base = npc_mem_pkg::PMEM_BASE + npc_mem_pkg::addr_t'(PMEM_WORDS * 4 - 8);
		load_beats(4, 1'b0);
		axi_write_burst(4'd8, base, 8'd3, npc_mem_pkg::BURST_INCR, bresp);
		check_resp("crossing write resp", npc_mem_pkg::RESP_DECERR, bresp.resp);
		check_id("crossing write id", 4'd8, bresp.id);
		model_burst(base);
		axi_read_burst(4'd8, base, 8'd1, npc_mem_pkg::BURST_INCR, 1'b0, lat);
		check_pmem_beats(base, 2, 4'd8);
		end_test();
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		aw_valid = 1'b0;
		aw = '0;
		w_valid = 1'b0;
		w = '0;
		b_ready = 1'b0;
		ar_valid = 1'b0;
		ar = '0;
		r_ready = 1'b0;
		serial_ready = 1'b0;
		rng = 32'd12;
		err_count = 0;
		test_errs_start = 0;
		tests_run = 0;
		tests_failed = 0;
		assert_fails = 0;
		cycles = 0;
		b_done_cycle = 0;
		drain_start_cycle = 0;
		for (int i = 0; i < PMEM_WORDS; i++) begin
			ref_mem[i] = '0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_boot_stub();
		test_strobed_write();
		test_read_backpressure();
		test_serial_out();
		test_error_responses();

		repeat (2) @(negedge clk);
		assert_fails = u_npc_mem_top.u_axi_mem_slave.u_npc_mem_chk.fail_count;
		$display("%0d tests run, %0d failed, %0d check errors, %0d assertion failures",
			tests_run, tests_failed, err_count, assert_fails);
		if (tests_failed == 0 && err_count == 0 && assert_fails == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* src/axi_mem_slave.sv */
`timescale 1ns/1ps

module axi_mem_slave (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  aw_valid,
	input  npc_mem_pkg::axi_aw_t  aw,
	output logic                  aw_ready,
	input  logic                  w_valid,
	input  npc_mem_pkg::axi_w_t   w,
	output logic                  w_ready,
	output logic                  b_valid,
	output npc_mem_pkg::axi_b_t   b,
	input  logic                  b_ready,
	input  logic                  ar_valid,
	input  npc_mem_pkg::axi_ar_t  ar,
	output logic                  ar_ready,
	output logic                  r_valid,
	output npc_mem_pkg::axi_r_t   r,
	input  logic                  r_ready,
	output logic                  req_valid,
	output npc_mem_pkg::mem_req_t req,
	input  logic                  req_ready,
	input  npc_mem_pkg::resp_t    wr_resp,
	input  logic                  rsp_valid,
	input  npc_mem_pkg::data_t    rsp_data,
	input  npc_mem_pkg::resp_t    rsp_resp
);

	typedef enum logic [1:0] {
		IDLE,
		READ,
		WRITE
	} state_t;

	state_t state;
	logic armed;

	// latched burst
	npc_mem_pkg::axi_id_t id_q;
	npc_mem_pkg::addr_t addr_q;
	npc_mem_pkg::axi_len_t len_q;
	npc_mem_pkg::axi_burst_t burst_q;

	// read bookkeeping
	npc_mem_pkg::axi_len_t iss_cnt;
	npc_mem_pkg::axi_len_t ld_cnt;
	logic iss_done;
	logic rsp_pend;
	logic r_free;
	logic r_load;
	logic rd_issue;

	// write bookkeeping
	npc_mem_pkg::resp_t wr_worst;
	npc_mem_pkg::resp_t wr_worst_next;
	logic wr_req;
	logic req_fire;

	// address channels stay closed until the cycle after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			armed <= 1'b0;
		end else begin
			armed <= 1'b1;
		end
	end

	// reads take priority over a simultaneous write
	assign ar_ready = armed && (state == IDLE);
	assign aw_ready = armed && (state == IDLE) && !ar_valid;

	// R slot is usable if empty or being taken this cycle
	assign r_free = !r_valid || r_ready;
	assign r_load = (rsp_valid || rsp_pend) && r_free;

	assign rd_issue = (state == READ) && !iss_done && r_free;
	assign wr_req = (state == WRITE) && !b_valid && w_valid;
	assign req_valid = rd_issue || wr_req;
	assign req_fire = req_valid && req_ready;
	assign w_ready = (state == WRITE) && !b_valid && req_ready;

	assign wr_worst_next = (wr_resp > wr_worst) ? wr_resp : wr_worst;

	always_comb begin
		req.we = (state == WRITE);
		req.addr = {addr_q[31:2], 2'b00};
		req.wdata = req.we ? w.data : '0;
		req.strb = req.we ? w.strb : '0;
	end

	assign b.id = id_q;
	assign b.resp = wr_worst;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			iss_cnt <= '0;
			iss_done <= 1'b0;
			ld_cnt <= '0;
			rsp_pend <= 1'b0;
			r_valid <= 1'b0;
			b_valid <= 1'b0;
			wr_worst <= npc_mem_pkg::RESP_OKAY;
		end else begin
			case (state)
				IDLE: begin
					if (ar_valid && ar_ready) begin
						state <= READ;
						iss_cnt <= '0;
						iss_done <= 1'b0;
						ld_cnt <= '0;
					end else if (aw_valid && aw_ready) begin
						state <= WRITE;
						wr_worst <= npc_mem_pkg::RESP_OKAY;
					end
				end
				READ: begin
					if (rd_issue && req_ready) begin
						iss_cnt <= iss_cnt + 1'b1;
						if (iss_cnt == len_q) begin
							iss_done <= 1'b1;
						end
					end
					if (r_load) begin
						ld_cnt <= ld_cnt + 1'b1;
					end
					if (r_valid && r_ready && r.last) begin
						state <= IDLE;
					end
				end
				WRITE: begin
					if (req_fire) begin
						wr_worst <= wr_worst_next;
						if (w.last) begin
							b_valid <= 1'b1;
						end
					end
					if (b_valid && b_ready) begin
						b_valid <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase

			if (r_load) begin
				r_valid <= 1'b1;
			end else if (r_ready) begin
				r_valid <= 1'b0;
			end

			// region map holds its read data until the next request, so a
			// response that finds the R slot busy is parked and taken later
			if (rsp_valid && !r_free) begin
				rsp_pend <= 1'b1;
			end else if (r_load) begin
				rsp_pend <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ar_valid && ar_ready) begin
			id_q <= ar.id;
			addr_q <= ar.addr;
			len_q <= ar.len;
			burst_q <= ar.burst;
		end else if (aw_valid && aw_ready) begin
			id_q <= aw.id;
			addr_q <= aw.addr;
			len_q <= aw.len;
			burst_q <= aw.burst;
		end else if (req_fire && burst_q == npc_mem_pkg::BURST_INCR) begin
			addr_q <= addr_q + 32'd4;
		end
	end

	// R output register
	always_ff @(posedge clk) begin
		if (r_load) begin
			r.id <= id_q;
			r.data <= rsp_data;
			r.resp <= rsp_resp;
			r.last <= (ld_cnt == len_q);
		end
	end

endmodule

/* src/mem_region_map.sv */
`timescale 1ns/1ps

module mem_region_map #(
	parameter int PMEM_WORDS = 1024
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          req_valid,
	input  npc_mem_pkg::mem_req_t         req,
	output logic                          req_ready,
	output npc_mem_pkg::resp_t            wr_resp,
	output logic                          rsp_valid,
	output npc_mem_pkg::data_t            rsp_data,
	output npc_mem_pkg::resp_t            rsp_resp,
	output logic                          mem_en,
	output logic                          mem_we,
	output logic [$clog2(PMEM_WORDS)-1:0] mem_index,
	output npc_mem_pkg::data_t            mem_wdata,
	output npc_mem_pkg::strb_t            mem_strb,
	input  npc_mem_pkg::data_t            mem_rdata,
	output logic                          ser_push,
	output logic [7:0]                    ser_byte,
	input  logic                          ser_full
);

	localparam int IDX_W = $clog2(PMEM_WORDS);

	npc_mem_pkg::addr_t pmem_off;
	logic hit_pmem;
	logic hit_boot;
	logic hit_serial;
	logic fire;
	npc_mem_pkg::resp_t rd_resp;

	// read return state
	logic rd_pmem_q;
	npc_mem_pkg::data_t rd_word_q;

	// below PMEM_BASE the offset wraps to a large value and misses
	assign pmem_off = req.addr - npc_mem_pkg::PMEM_BASE;
	assign hit_pmem = pmem_off < npc_mem_pkg::addr_t'(PMEM_WORDS * 4);
	assign hit_boot = (req.addr[31:4] == npc_mem_pkg::BOOT_BASE[31:4]);
	assign hit_serial = (req.addr == npc_mem_pkg::SERIAL_ADDR);

	// only a serial write into a full FIFO stalls
	assign req_ready = !(hit_serial && req.we && ser_full);
	assign fire = req_valid && req_ready;

	always_comb begin
		if (hit_pmem || hit_serial) begin
			wr_resp = npc_mem_pkg::RESP_OKAY;
		end else if (hit_boot) begin
			wr_resp = npc_mem_pkg::RESP_SLVERR;
		end else begin
			wr_resp = npc_mem_pkg::RESP_DECERR;
		end
	end

	assign rd_resp = (hit_pmem || hit_boot || hit_serial) ?
		npc_mem_pkg::RESP_OKAY : npc_mem_pkg::RESP_DECERR;

	assign mem_en = fire && hit_pmem;
	assign mem_we = req.we;
	assign mem_index = pmem_off[IDX_W+1:2];
	assign mem_wdata = req.wdata;
	assign mem_strb = req.strb;

	assign ser_push = fire && hit_serial && req.we && req.strb[0];
	assign ser_byte = req.wdata[7:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= fire && !req.we;
		end
	end

	// held until the next accepted read
	always_ff @(posedge clk) begin
		if (fire && !req.we) begin
			rd_pmem_q <= hit_pmem;
			rd_word_q <= hit_boot ? npc_mem_pkg::BOOT_ROM[req.addr[3:2]] : '0;
			rsp_resp <= rd_resp;
		end
	end

	assign rsp_data = rd_pmem_q ? mem_rdata : rd_word_q;

endmodule

/* src/npc_mem_pkg.sv */
package npc_mem_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] strb_t;
	typedef logic [3:0] axi_id_t;
	typedef logic [7:0] axi_len_t;
	typedef logic [2:0] axi_size_t;
	typedef logic [1:0] axi_burst_t;
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;
	localparam resp_t RESP_DECERR = 2'd3;

	localparam axi_burst_t BURST_FIXED = 2'd0;
	localparam axi_burst_t BURST_INCR = 2'd1;

	// address map
	localparam addr_t PMEM_BASE = 32'h8000_0000;
	localparam addr_t BOOT_BASE = 32'h3000_0000;
	localparam addr_t SERIAL_ADDR = 32'ha000_03f8;

	// jump-to-program stub, word 0 sits in the low slot
	localparam data_t [3:0] BOOT_ROM = {32'h0, 32'h0, 32'h00010067, 32'h80000137};

	typedef struct packed {
		axi_id_t id;
		addr_t addr;
		axi_len_t len;
		axi_size_t size;
		axi_burst_t burst;
	} axi_aw_t;

	typedef struct packed {
		axi_id_t id;
		addr_t addr;
		axi_len_t len;
		axi_size_t size;
		axi_burst_t burst;
	} axi_ar_t;

	typedef struct packed {
		data_t data;
		strb_t strb;
		logic last;
	} axi_w_t;

	typedef struct packed {
		axi_id_t id;
		resp_t resp;
	} axi_b_t;

	typedef struct packed {
		axi_id_t id;
		data_t data;
		resp_t resp;
		logic last;
	} axi_r_t;

	// one word access toward the region map
	typedef struct packed {
		logic we;
		addr_t addr;
		data_t wdata;
		strb_t strb;
	} mem_req_t;

endpackage

/* src/npc_mem_top.sv */
`timescale 1ns/1ps

module npc_mem_top #(
	parameter int PMEM_WORDS = 1024,
	parameter int SERIAL_DEPTH = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 aw_valid,
	input  npc_mem_pkg::axi_aw_t aw,
	output logic                 aw_ready,
	input  logic                 w_valid,
	input  npc_mem_pkg::axi_w_t  w,
	output logic                 w_ready,
	output logic                 b_valid,
	output npc_mem_pkg::axi_b_t  b,
	input  logic                 b_ready,
	input  logic                 ar_valid,
	input  npc_mem_pkg::axi_ar_t ar,
	output logic                 ar_ready,
	output logic                 r_valid,
	output npc_mem_pkg::axi_r_t  r,
	input  logic                 r_ready,
	output logic                 serial_valid,
	output logic [7:0]           serial_byte,
	input  logic                 serial_ready
);

	// slave to region map
	logic req_valid;
	npc_mem_pkg::mem_req_t req;
	logic req_ready;
	npc_mem_pkg::resp_t wr_resp;
	logic rsp_valid;
	npc_mem_pkg::data_t rsp_data;
	npc_mem_pkg::resp_t rsp_resp;

	// region map to memory
	logic mem_en;
	logic mem_we;
	logic [$clog2(PMEM_WORDS)-1:0] mem_index;
	npc_mem_pkg::data_t mem_wdata;
	npc_mem_pkg::strb_t mem_strb;
	npc_mem_pkg::data_t mem_rdata;

	// region map to serial sink
	logic ser_push;
	logic [7:0] ser_byte;
	logic ser_full;

	axi_mem_slave u_axi_mem_slave (
		.clk       (clk),
		.rst       (rst),
		.aw_valid  (aw_valid),
		.aw        (aw),
		.aw_ready  (aw_ready),
		.w_valid   (w_valid),
		.w         (w),
		.w_ready   (w_ready),
		.b_valid   (b_valid),
		.b         (b),
		.b_ready   (b_ready),
		.ar_valid  (ar_valid),
		.ar        (ar),
		.ar_ready  (ar_ready),
		.r_valid   (r_valid),
		.r         (r),
		.r_ready   (r_ready),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.wr_resp   (wr_resp),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.rsp_resp  (rsp_resp)
	);

	mem_region_map #(
		.PMEM_WORDS (PMEM_WORDS)
	) u_mem_region_map (
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req       (req),
		.req_ready (req_ready),
		.wr_resp   (wr_resp),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.rsp_resp  (rsp_resp),
		.mem_en    (mem_en),
		.mem_we    (mem_we),
		.mem_index (mem_index),
		.mem_wdata (mem_wdata),
		.mem_strb  (mem_strb),
		.mem_rdata (mem_rdata),
		.ser_push  (ser_push),
		.ser_byte  (ser_byte),
		.ser_full  (ser_full)
	);

	pmem_sram #(
		.PMEM_WORDS (PMEM_WORDS)
	) u_pmem_sram (
		.clk   (clk),
		.en    (mem_en),
		.we    (mem_we),
		.index (mem_index),
		.wdata (mem_wdata),
		.strb  (mem_strb),
		.rdata (mem_rdata)
	);

	serial_sink #(
		.SERIAL_DEPTH (SERIAL_DEPTH)
	) u_serial_sink (
		.clk          (clk),
		.rst          (rst),
		.push         (ser_push),
		.byte_in      (ser_byte),
		.full         (ser_full),
		.serial_valid (serial_valid),
		.serial_byte  (serial_byte),
		.serial_ready (serial_ready)
	);

endmodule

/* src/pmem_sram.sv */
`timescale 1ns/1ps

module pmem_sram #(
	parameter int PMEM_WORDS = 1024
) (
	input  logic                          clk,
	input  logic                          en,
	input  logic                          we,
	input  logic [$clog2(PMEM_WORDS)-1:0] index,
	input  npc_mem_pkg::data_t            wdata,
	input  npc_mem_pkg::strb_t            strb,
	output npc_mem_pkg::data_t            rdata
);

	npc_mem_pkg::data_t mem [PMEM_WORDS];

	// start from a zeroed image
	initial begin
		for (int i = 0; i < PMEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always @(posedge clk) begin
		if (en && we) begin
			for (int b = 0; b < 4; b++) begin
				if (strb[b]) begin
					mem[index][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

	// rdata only moves on a read, it holds otherwise
	always_ff @(posedge clk) begin
		if (en && !we) begin
			rdata <= mem[index];
		end
	end

endmodule

/* src/serial_sink.sv */
`timescale 1ns/1ps

module serial_sink #(
	parameter int SERIAL_DEPTH = 4
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       push,
	input  logic [7:0] byte_in,
	output logic       full,
	output logic       serial_valid,
	output logic [7:0] serial_byte,
	input  logic       serial_ready
);

	localparam int PTR_W = (SERIAL_DEPTH > 1) ? $clog2(SERIAL_DEPTH) : 1;
	localparam int CNT_W = $clog2(SERIAL_DEPTH + 1);

	logic [7:0] fifo [SERIAL_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic wr_en;
	logic pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(SERIAL_DEPTH - 1)) begin
			return '0;
		end
		return p + 1'b1;
	endfunction

	assign full = (count == CNT_W'(SERIAL_DEPTH));
	assign serial_valid = (count != '0);
	assign serial_byte = fifo[rd_ptr];

	assign wr_en = push && !full;
	assign pop = serial_valid && serial_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({wr_en, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (wr_en) begin
			fifo[wr_ptr] <= byte_in;
		end
	end

endmodule
